// ==== verilog/dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

   // one data word and one byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // address split: tag 31..6, set 5..3, word select 2, byte 1..0
   typedef logic [25:0] tag_t;
   typedef logic [2:0]  set_idx_t;

   localparam int NUM_SETS = 8;
   localparam int NUM_WAYS = 2;

   // way number, also the per-set victim bit
   typedef logic way_t;

   typedef struct packed {
      tag_t  tag;
      word_t word0;
      word_t word1;
      logic  dirty;
      logic  valid;
   } line_t;

   // both lines of one set, indexed by way
   typedef line_t [NUM_WAYS-1:0] set_lines_t;

   function automatic tag_t addr_tag(input addr_t addr);
      return addr[31:6];
   endfunction

   function automatic set_idx_t addr_set(input addr_t addr);
      return addr[5:3];
   endfunction

   // high means word1 of the block
   function automatic logic addr_word(input addr_t addr);
      return addr[2];
   endfunction

   // rebuild a word address, byte bits are always zero
   function automatic addr_t block_addr(input tag_t tag, input set_idx_t idx, input logic word);
      return {tag, idx, word, 2'b00};
   endfunction

endpackage

`default_nettype wire

// ==== verilog/dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

   import dcache_geom_pkg::*;

   // processor request, held until hit
   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
      logic  halt;
   } cpu_req_t;

   typedef struct packed {
      logic  hit;
      word_t load;
      logic  flushed;
   } cpu_rsp_t;

   // one word request toward memory
   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } mem_req_t;

   // busy low completes the word, load valid in that cycle
   typedef struct packed {
      logic  busy;
      word_t load;
   } mem_rsp_t;

   // result of the tag compare
   typedef struct packed {
      logic  hit;
      way_t  way;
      word_t word;
   } lookup_t;

   // single line write into the store
   typedef struct packed {
      logic     en;
      set_idx_t set;
      way_t     way;
      line_t    line;
   } line_wr_t;

   typedef struct packed {
      logic     en;
      set_idx_t set;
      way_t     victim;
   } lru_wr_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_store.sv ====
`default_nettype none

module dcache_store (
   input  logic                        CLK,
   input  logic                        nRST,
   input  dcache_geom_pkg::set_idx_t   rd_set,
   input  dcache_bus_pkg::line_wr_t    line_wr,
   input  dcache_bus_pkg::lru_wr_t     lru_wr,
   output dcache_geom_pkg::set_lines_t set_lines,
   output dcache_geom_pkg::way_t       victim
);

   import dcache_geom_pkg::*;

   // line array, one entry holds both ways of a set
   set_lines_t lines [NUM_SETS];

   // way to replace next, one bit per set
   logic [NUM_SETS-1:0] victims;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         // all lines invalid, every set points at way 0
         for (int s = 0; s < NUM_SETS; s++)
         begin
            lines[s] <= '0;
         end
         victims <= '0;
      end
      else
      begin
         // one line per cycle
         if (line_wr.en)
         begin
            lines[line_wr.set][line_wr.way] <= line_wr.line;
         end
         // one lru bit per cycle, may hit a different set
         if (lru_wr.en)
         begin
            victims[lru_wr.set] <= lru_wr.victim;
         end
      end
   end

   // combinational read of a whole set
   assign set_lines = lines[rd_set];
   assign victim    = victims[rd_set];

   // a dirty line must also be valid, or the flush scan
   // and the victim write-back would disagree on what memory holds
   a_dirty_valid: assert property (
      @(posedge CLK) disable iff (!nRST)
      (line_wr.en && line_wr.line.dirty) |-> line_wr.line.valid
   ) else $error("store: line written dirty but not valid");

endmodule

`default_nettype wire

// ==== verilog/dcache_lookup.sv ====
`default_nettype none

module dcache_lookup (
   input  dcache_bus_pkg::cpu_req_t    req,
   input  dcache_geom_pkg::set_lines_t set_lines,
   output dcache_bus_pkg::lookup_t     result
);

   import dcache_geom_pkg::*;

   tag_t                req_tag;
   logic [NUM_WAYS-1:0] match;
   way_t                hit_way;
   line_t               hit_line;

   assign req_tag = addr_tag(req.addr);

   always_comb
   begin
      // a way matches only when valid with the same tag
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         match[w] = set_lines[w].valid && (set_lines[w].tag == req_tag);
      end

      // two ways, so way 1 when it matches, else way 0
      hit_way  = match[1];
      hit_line = set_lines[hit_way];

      // hit only counts for a live request
      result.hit  = (req.ren || req.wen) && (|match);
      result.way  = hit_way;
      // bit 2 picks the word inside the block
      result.word = addr_word(req.addr) ? hit_line.word1 : hit_line.word0;

      // refill always goes to a missing block, so a tag
      // never lives in both ways of one set
      a_one_way: assert final ($onehot0(match))
         else $error("lookup: tag matches in both ways");
   end

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
   input  logic                        CLK,
   input  logic                        nRST,
   input  dcache_bus_pkg::cpu_req_t    req,
   input  dcache_bus_pkg::lookup_t     result,
   input  dcache_geom_pkg::set_lines_t set_lines,
   input  dcache_geom_pkg::way_t       victim,
   input  dcache_bus_pkg::mem_rsp_t    mem_rsp,
   output dcache_bus_pkg::cpu_rsp_t    rsp,
   output dcache_bus_pkg::mem_req_t    mem_req,
   output dcache_geom_pkg::set_idx_t   rd_set,
   output dcache_bus_pkg::line_wr_t    line_wr,
   output dcache_bus_pkg::lru_wr_t     lru_wr
);

   import dcache_geom_pkg::*;

   typedef enum logic [3:0] {
      idle,
      wb0,
      wb1,
      fill0,
      fill1,
      scan,
      flush0,
      flush1,
      halted
   } state_t;

   // scan row: top bit is the way, the rest the set
   localparam int ROWS     = NUM_SETS * NUM_WAYS;
   localparam int ROW_W    = $clog2(ROWS);
   localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(ROWS - 1);

   state_t           state;
   state_t           next_state;
   way_t             miss_way;
   logic [ROW_W-1:0] scan_row;
   logic             scan_step;
   word_t            fill_word;

   tag_t     req_tag;
   set_idx_t req_set;
   logic     req_word;
   way_t     scan_way;
   set_idx_t scan_set;
   line_t    vline;
   line_t    sline;
   line_t    hline;

   assign req_tag  = addr_tag(req.addr);
   assign req_set  = addr_set(req.addr);
   assign req_word = addr_word(req.addr);

   // way 0 for all sets first, then way 1
   assign scan_way = scan_row[ROW_W-1];
   assign scan_set = scan_row[ROW_W-2:0];

   // victim line during a miss, scanned line during the flush
   assign vline = set_lines[miss_way];
   assign sline = set_lines[scan_way];
   assign hline = set_lines[result.way];

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= idle;
         miss_way <= '0;
         scan_row <= '0;
      end
      else
      begin
         state <= next_state;
         // victim is stable through the miss, so sample it while idle
         if (state == idle)
         begin
            miss_way <= victim;
         end
         // scan restarts from row 0 when leaving idle
         if (state == idle)
         begin
            scan_row <= '0;
         end
         else if (scan_step)
         begin
            scan_row <= scan_row + 1'b1;
         end
      end
   end

   // first refill word, held until the second arrives
   always_ff @(posedge CLK)
   begin
      if (state == fill0 && !mem_rsp.busy)
      begin
         fill_word <= mem_rsp.load;
      end
   end

   always_comb
   begin
      next_state  = state;
      scan_step   = 1'b0;
      rsp         = '0;
      rsp.load    = result.word;
      mem_req     = '0;
      line_wr     = '0;
      lru_wr      = '0;
      rd_set      = req_set;

      case (state)
         idle:
         begin
            // halt wins over any request
            if (req.halt)
            begin
               next_state = scan;
            end
            else if (result.hit)
            begin
               rsp.hit       = 1'b1;
               // the other way becomes the victim
               lru_wr.en     = 1'b1;
               lru_wr.set    = req_set;
               lru_wr.victim = ~result.way;
               if (req.wen)
               begin
                  // merge the store word, mark dirty
                  line_wr.en         = 1'b1;
                  line_wr.set        = req_set;
                  line_wr.way        = result.way;
                  line_wr.line       = hline;
                  line_wr.line.dirty = 1'b1;
                  if (req_word)
                  begin
                     line_wr.line.word1 = req.store;
                  end
                  else
                  begin
                     line_wr.line.word0 = req.store;
                  end
               end
            end
            else if (req.ren || req.wen)
            begin
               // miss, write back only a dirty victim
               if (set_lines[victim].valid && set_lines[victim].dirty)
               begin
                  next_state = wb0;
               end
               else
               begin
                  next_state = fill0;
               end
            end
         end
         wb0:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(vline.tag, req_set, 1'b0);
            mem_req.store = vline.word0;
            if (!mem_rsp.busy)
            begin
               next_state = wb1;
            end
         end
         wb1:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(vline.tag, req_set, 1'b1);
            mem_req.store = vline.word1;
            if (!mem_rsp.busy)
            begin
               next_state = fill0;
            end
         end
         fill0:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = block_addr(req_tag, req_set, 1'b0);
            if (!mem_rsp.busy)
            begin
               next_state = fill1;
            end
         end
         fill1:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = block_addr(req_tag, req_set, 1'b1);
            if (!mem_rsp.busy)
            begin
               // install the block in the victim way
               line_wr.en         = 1'b1;
               line_wr.set        = req_set;
               line_wr.way        = miss_way;
               line_wr.line.tag   = req_tag;
               line_wr.line.word0 = fill_word;
               line_wr.line.word1 = mem_rsp.load;
               line_wr.line.dirty = req.wen;
               line_wr.line.valid = 1'b1;
               lru_wr.en          = 1'b1;
               lru_wr.set         = req_set;
               lru_wr.victim      = ~miss_way;
               // request hits on the next idle cycle
               next_state         = idle;
            end
         end
         scan:
         begin
            rd_set = scan_set;
            if (sline.valid && sline.dirty)
            begin
               next_state = flush0;
            end
            else if (scan_row == LAST_ROW)
            begin
               next_state = halted;
            end
            else
            begin
               scan_step = 1'b1;
            end
         end
         flush0:
         begin
            rd_set        = scan_set;
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(sline.tag, scan_set, 1'b0);
            mem_req.store = sline.word0;
            if (!mem_rsp.busy)
            begin
               next_state = flush1;
            end
         end
         flush1:
         begin
            rd_set        = scan_set;
            mem_req.wen   = 1'b1;
            mem_req.addr  = block_addr(sline.tag, scan_set, 1'b1);
            mem_req.store = sline.word1;
            if (!mem_rsp.busy)
            begin
               // block is clean once both words are out
               line_wr.en         = 1'b1;
               line_wr.set        = scan_set;
               line_wr.way        = scan_way;
               line_wr.line       = sline;
               line_wr.line.dirty = 1'b0;
               if (scan_row == LAST_ROW)
               begin
                  next_state = halted;
               end
               else
               begin
                  scan_step  = 1'b1;
                  next_state = scan;
               end
            end
         end
         halted:
         begin
            rsp.flushed = 1'b1;
         end
         default:
         begin
            next_state = idle;
         end
      endcase
   end

   // memory sees one direction at a time
   a_one_dir: assert property (
      @(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen)
   ) else $error("ctrl: memory read and write together");

   // once flushed, flushed holds and memory stays quiet
   a_quiet_halt: assert property (
      @(posedge CLK) disable iff (!nRST)
      rsp.flushed |=> rsp.flushed && !(mem_req.ren || mem_req.wen)
   ) else $error("ctrl: memory request after flush");

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`default_nettype none

module dcache_top (
   input  logic                     CLK,
   input  logic                     nRST,
   input  dcache_bus_pkg::cpu_req_t cpu_req,
   output dcache_bus_pkg::cpu_rsp_t cpu_rsp,
   output dcache_bus_pkg::mem_req_t mem_req,
   input  dcache_bus_pkg::mem_rsp_t mem_rsp
);

   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   // set selected by control, read back whole
   set_idx_t   rd_set;
   set_lines_t set_lines;
   way_t       victim;

   // compare result and write ports
   lookup_t    result;
   line_wr_t   line_wr;
   lru_wr_t    lru_wr;

   dcache_store store_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .rd_set    (rd_set),
      .line_wr   (line_wr),
      .lru_wr    (lru_wr),
      .set_lines (set_lines),
      .victim    (victim)
   );

   dcache_lookup lookup_i (
      .req       (cpu_req),
      .set_lines (set_lines),
      .result    (result)
   );

   dcache_ctrl ctrl_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .req       (cpu_req),
      .result    (result),
      .set_lines (set_lines),
      .victim    (victim),
      .mem_rsp   (mem_rsp),
      .rsp       (cpu_rsp),
      .mem_req   (mem_req),
      .rd_set    (rd_set),
      .line_wr   (line_wr),
      .lru_wr    (lru_wr)
   );

endmodule

`default_nettype wire

// ==== testbench/mem_model.sv ====
`default_nettype none

module mem_model (
   input  logic                     CLK,
   input  logic                     nRST,
   input  dcache_bus_pkg::mem_req_t mem_req,
   output dcache_bus_pkg::mem_rsp_t mem_rsp
);

   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   // word storage, the testbench fills a block before its first use
   word_t mem [addr_t];

   // completed words, read by the testbench as deltas
   int reads  = 0;
   int writes = 0;

   // busy cycles left before the current word completes
   logic [1:0] wait_cnt;
   logic       active;

   assign active = mem_req.ren || mem_req.wen;

   always_comb
   begin
      mem_rsp.busy = active && (wait_cnt != 2'd0);
      mem_rsp.load = '0;
      // read data valid whenever a read is pending
      if (mem_req.ren && mem.exists(mem_req.addr))
      begin
         mem_rsp.load = mem[mem_req.addr];
      end
   end

   always @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         wait_cnt <= 2'd0;
      end
      else if (active)
      begin
         if (wait_cnt == 2'd0)
         begin
            // word completes on this edge
            if (mem_req.wen)
            begin
               mem[mem_req.addr] = mem_req.store;
               writes = writes + 1;
            end
            else
            begin
               reads = reads + 1;
            end
            // zero to three busy cycles for the next word
            wait_cnt <= 2'($urandom % 4);
         end
         else
         begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== testbench/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;

   // one count per request issued below, halts included
   localparam int NUM_REQUESTS   = 220;
   localparam int CYCLES_PER_REQ = 200;

   logic     CLK;
   logic     nRST;
   cpu_req_t cpu_req;
   cpu_rsp_t cpu_rsp;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;

   // words stored by the processor, by address
   word_t shadow [addr_t];
   int    errors;

   dcache_top dcache_top_i (
      .CLK     (CLK),
      .nRST    (nRST),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   mem_model mem_i (
      .CLK     (CLK),
      .nRST    (nRST),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   always #20 CLK = ~CLK;

   // fixed mix of every address bit
   function automatic word_t init_word(input addr_t a);
      return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
   endfunction

   // last stored word, else what memory started with
   function automatic word_t expected_load(input addr_t a);
      if (shadow.exists(a))
      begin
         return shadow[a];
      end
      return init_word(a);
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp)
      begin
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_hit_count(input int got, input int exp, input string what);
      if (got != exp)
      begin
         report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
      end
   endtask

   task automatic check_flushed(input cpu_rsp_t rsp, input string what);
      if (rsp.flushed !== 1'b1 || rsp.hit !== 1'b0)
      begin
         report_error($sformatf("%s: flushed %b hit %b", what, rsp.flushed, rsp.hit));
      end
   endtask

   task automatic apply_reset();
      nRST    = 1'b0;
      cpu_req = '0;
      repeat (16) @(posedge CLK);
      #5;
      nRST = 1'b1;
   endtask

   // memory gets both initial words of a block on first use
   task automatic preload(input addr_t a);
      addr_t w0;
      addr_t w1;
      w0 = {a[31:3], 3'b000};
      w1 = {a[31:3], 3'b100};
      if (!mem_i.mem.exists(w0))
         mem_i.mem[w0] = init_word(w0);
      if (!mem_i.mem.exists(w1))
         mem_i.mem[w1] = init_word(w1);
   endtask

   // request held until hit, dropped after the next edge
   task automatic access(input logic wr, input addr_t a, input word_t d);
      preload(a);
      @(posedge CLK);
      #5;
      cpu_req.ren   = !wr;
      cpu_req.wen   = wr;
      cpu_req.addr  = a;
      cpu_req.store = d;
      do
         @(negedge CLK);
      while (cpu_rsp.hit !== 1'b1);
      @(posedge CLK);
      #5;
      cpu_req.ren = 1'b0;
      cpu_req.wen = 1'b0;
   endtask

   task automatic halt_and_check();
      @(posedge CLK);
      #5;
      cpu_req.halt = 1'b1;
      do
         @(negedge CLK);
      while (cpu_rsp.flushed !== 1'b1);
      // every stored word must have reached memory
      foreach (shadow[a])
      begin
         check_word(mem_i.mem[a], shadow[a], $sformatf("memory at %h after flush", a));
      end
      // bus stays quiet, the compare process watches it
      repeat (10) @(negedge CLK);
      // flushed holds until reset
      check_flushed(cpu_rsp, "ten cycles after flushed");
      @(posedge CLK);
      #5;
   endtask

   // compare every hit, track stores, police the bus after flush
   always @(negedge CLK)
   begin
      if (nRST && cpu_rsp.hit)
      begin
         if (cpu_req.ren)
            check_word(cpu_rsp.load, expected_load(cpu_req.addr),
                       $sformatf("load at %h", cpu_req.addr));
         else
            shadow[cpu_req.addr] = cpu_req.store;
      end
      if (nRST && cpu_rsp.flushed && (mem_req.ren || mem_req.wen))
         report_error("memory request seen after flushed was raised");
   end

   initial
   begin
      int    r0;
      int    w0;
      int    op;
      int    idx;
      addr_t pool [$];
      void'($urandom(32'h3f2e));
      CLK    = 1'b0;
      errors = 0;
      apply_reset();

      // cold read miss, one block refill
      r0 = mem_i.reads;
      access(1'b0, 32'h0000_1000, '0);
      check_hit_count(mem_i.reads - r0, 2, "reads for cold miss");

      // write then read in the same block, no bus traffic
      r0 = mem_i.reads;
      w0 = mem_i.writes;
      access(1'b1, 32'h0000_1004, 32'hcafe_0001);
      access(1'b0, 32'h0000_1004, '0);
      check_hit_count(mem_i.reads - r0, 0, "reads for write and read hit");
      check_hit_count(mem_i.writes - w0, 0, "writes for write and read hit");

      // set 2, dirty A evicted by C
      access(1'b1, 32'h0000_2010, 32'h1234_5678);
      access(1'b0, 32'h0000_3010, '0);
      w0 = mem_i.writes;
      access(1'b0, 32'h0000_4010, '0);
      check_hit_count(mem_i.writes - w0, 2, "write-back words for evicted A");
      check_word(mem_i.mem[32'h0000_2010], expected_load(32'h0000_2010), "A word0 in memory");
      check_word(mem_i.mem[32'h0000_2014], expected_load(32'h0000_2014), "A word1 in memory");
      access(1'b0, 32'h0000_2010, '0);

      // set 4, touching A again makes B the victim
      access(1'b0, 32'h0000_5020, '0);
      access(1'b0, 32'h0000_6020, '0);
      access(1'b0, 32'h0000_5020, '0);
      access(1'b0, 32'h0000_7020, '0);
      r0 = mem_i.reads;
      access(1'b0, 32'h0000_5020, '0);
      check_hit_count(mem_i.reads - r0, 0, "reads for A after C replaced B");

      // scattered stores, then flush
      for (int i = 0; i < 6; i++)
      begin
         access(1'b1, 32'h0000_8000 + 32'(i * 72), 32'ha5a5_0000 + 32'(i));
      end
      halt_and_check();
      apply_reset();

      // three tags in sets 1 and 5
      for (int t = 0; t < 3; t++)
         for (int s = 0; s < 2; s++)
            for (int w = 0; w < 2; w++)
               pool.push_back({26'h100 + 26'(t), 3'(1 + 4 * s), 1'(w), 2'b00});
      for (int n = 0; n < 200; n++)
      begin
         op  = $urandom % 2;
         idx = $urandom % pool.size();
         access(op[0], pool[idx], $urandom);
      end
      halt_and_check();

      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // bound on the whole run
   initial
   begin
      repeat (NUM_REQUESTS * CYCLES_PER_REQ) @(posedge CLK);
      $display("watchdog expired because the cache stopped answering requests");
      $display("SOME TESTS FAILED");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/dcache_geom_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_store.sv
verilog/dcache_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module dcache_tb -f vlog.f -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
echo "pass message not found"
exit 1
